// ==== verilog/rv32i_pkg.sv ====
// Shared definitions for the RV32I pipeline
//   Widths, reset address and the fetch bubble
//   Opcode, ALU, branch and forwarding enums
//   Control word and pipeline register structs

`default_nettype none

package rv32i_pkg;

  // Widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // Fetch constants
  localparam logic [xlen-1:0] pc_step  = 32'd4;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
  localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;  // addi x0, x0, 0

  // Major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    op_r      = 7'b0110011,  // add sub and or
    op_imm    = 7'b0010011,  // addi andi ori xori
    op_load   = 7'b0000011,  // lw
    op_store  = 7'b0100011,  // sw
    op_branch = 7'b1100011,  // beq bne
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_lui    = 7'b0110111
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    alu_add    = 3'd0,
    alu_sub    = 3'd1,
    alu_and    = 3'd2,
    alu_or     = 3'd3,
    alu_xor    = 3'd4,
    alu_pass_b = 3'd5   // Operand b straight through, for lui
  } alu_op_e;

  // Branch condition in funct3
  typedef enum logic [2:0] {
    br_eq = 3'b000,
    br_ne = 3'b001
  } br_e;

  // Operand source in execute
  typedef enum logic [1:0] {
    fwd_none = 2'b00,   // Register file value from decode
    fwd_mem  = 2'b01,   // Execute/memory register
    fwd_wb   = 2'b10    // Memory/writeback register
  } fwd_e;

  ////////////////////////////////
  // Control and pipeline structs
  ////////////////////////////////

  // All zero is a bubble
  typedef struct packed {
    logic    regwrite;  // Writes rd
    logic    alusrc;    // Immediate on ALU port b
    logic    memtoreg;  // Load
    logic    memwrite;  // Store
    logic    branch;    // beq or bne
    logic    jal;
    logic    jalr;
    logic    lui;       // rs1 field is immediate bits
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    br_e                   funct3;
    ctrl_t                 ctrl;
  } id_ex_t;

  typedef struct packed {
    logic [xlen-1:0]       alu_result;  // Also the data address
    logic [xlen-1:0]       store_data;
    logic [xlen-1:0]       link_addr;   // pc + 4 of the jump
    logic [reg_addr_w-1:0] rd;
    logic                  regwrite;
    logic                  memtoreg;
    logic                  memwrite;
    logic                  link;        // jal or jalr
  } ex_mem_t;

  typedef struct packed {
    logic [xlen-1:0]       wb_data;
    logic [reg_addr_w-1:0] rd;
    logic                  regwrite;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== verilog/rv32i_decoder.sv ====
// RV32I instruction decoder
//   Control word from opcode, funct3 and funct7
//   Register indices and branch condition fields
//   Sign-extended I, S, B, J or U immediate

`timescale 1ns/1ps
`default_nettype none

module rv32i_decoder (
  input  logic [rv32i_pkg::xlen-1:0]       inst,
  output rv32i_pkg::ctrl_t                 ctrl,
  output logic [rv32i_pkg::reg_addr_w-1:0] rs1,
  output logic [rv32i_pkg::reg_addr_w-1:0] rs2,
  output logic [rv32i_pkg::reg_addr_w-1:0] rd,
  output logic [rv32i_pkg::xlen-1:0]       imm,
  output rv32i_pkg::br_e                   funct3
);

  import rv32i_pkg::*;

  opcode_e opcode;
  logic    sub_bit;   // funct7[5]

  assign opcode  = opcode_e'(inst[6:0]);
  assign sub_bit = inst[30];
  assign rs1     = inst[19:15];
  assign rs2     = inst[24:20];
  assign rd      = inst[11:7];
  assign funct3  = br_e'(inst[14:12]);  // Only read for branches

  // Control word
  always_comb
  begin
    ctrl = '0;  // Unknown opcode gives a bubble
    case (opcode)
      op_r:
      begin
        ctrl.regwrite = 1'b1;
        case (inst[14:12])
          3'b000:  ctrl.alu_op = sub_bit ? alu_sub : alu_add;
          3'b110:  ctrl.alu_op = alu_or;
          3'b111:  ctrl.alu_op = alu_and;
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_imm:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        case (inst[14:12])
          3'b100:  ctrl.alu_op = alu_xor;
          3'b110:  ctrl.alu_op = alu_or;
          3'b111:  ctrl.alu_op = alu_and;
          default: ctrl.alu_op = alu_add;  // addi
        endcase
      end
      op_load:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;  // Address is rs1 + imm
        ctrl.memtoreg = 1'b1;
      end
      op_store:
      begin
        ctrl.alusrc   = 1'b1;
        ctrl.memwrite = 1'b1;
      end
      op_branch:
      begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = alu_sub;  // Zero flag means equal
      end
      op_jal:
      begin
        ctrl.regwrite = 1'b1;   // Link
        ctrl.jal      = 1'b1;
      end
      op_jalr:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;   // Target from ALU sum
        ctrl.jalr     = 1'b1;
      end
      op_lui:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.lui      = 1'b1;
        ctrl.alu_op   = alu_pass_b;
      end
      default: ;
    endcase
    // Hazard unit and writeback both assume a store never writes rd
    assert (!(ctrl.memwrite && ctrl.regwrite))
      else $error("decoder sets memwrite and regwrite together");
  end

  // Immediate by format
  always_comb
  begin
    case (opcode)
      op_store:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      op_branch: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      op_jal:    imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      op_lui:    imm = {inst[31:12], 12'b0};
      default:   imm = {{20{inst[31]}}, inst[31:20]};  // I-type
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/rv32i_regfile.sv ====
// RV32I integer register file
//   31 writable registers, x0 reads as zero
//   Two combinational read ports, one write port
//   Same-cycle write passes through to the read ports

`timescale 1ns/1ps
`default_nettype none

module rv32i_regfile (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             we,
  input  logic [rv32i_pkg::reg_addr_w-1:0] waddr,
  input  logic [rv32i_pkg::xlen-1:0]       wdata,
  input  logic [rv32i_pkg::reg_addr_w-1:0] raddr_a,
  input  logic [rv32i_pkg::reg_addr_w-1:0] raddr_b,
  output logic [rv32i_pkg::xlen-1:0]       rdata_a,
  output logic [rv32i_pkg::xlen-1:0]       rdata_b
);

  import rv32i_pkg::*;

  logic [xlen-1:0] regs [1:31];  // No storage for x0

  // Write port, fed from writeback
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we && waddr != '0)
      regs[waddr] <= wdata;
  end

  // Read ports with write-through
  assign rdata_a = (raddr_a == '0)                ? '0 :
                   (we && raddr_a == waddr)       ? wdata : regs[raddr_a];
  assign rdata_b = (raddr_b == '0)                ? '0 :
                   (we && raddr_b == waddr)       ? wdata : regs[raddr_b];

endmodule

`default_nettype wire

// ==== verilog/rv32i_alu.sv ====
// RV32I ALU
//   add, sub, and, or, xor and pass-b
//   Zero flag for beq and bne

`timescale 1ns/1ps
`default_nettype none

module rv32i_alu (
  input  logic [rv32i_pkg::xlen-1:0] a,
  input  logic [rv32i_pkg::xlen-1:0] b,
  input  rv32i_pkg::alu_op_e         op,
  output logic [rv32i_pkg::xlen-1:0] result,
  output logic                       zero
);

  import rv32i_pkg::*;

  always_comb
  begin
    case (op)
      alu_add:    result = a + b;   // Also addresses and jalr target
      alu_sub:    result = a - b;   // Branch compare
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_pass_b: result = b;       // lui
      default:    result = a + b;
    endcase
  end

  // Equal operands on sub
  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== verilog/rv32i_hazard.sv ====
// RV32I hazard unit
//   Forwarding selects for both execute operands
//   Load-use stall against the decode sources
//   Flush of younger instructions on a redirect

`timescale 1ns/1ps
`default_nettype none

module rv32i_hazard (
  input  logic [rv32i_pkg::reg_addr_w-1:0] id_rs1,
  input  logic [rv32i_pkg::reg_addr_w-1:0] id_rs2,
  input  rv32i_pkg::id_ex_t                id_ex,
  input  logic [rv32i_pkg::reg_addr_w-1:0] mem_rd,
  input  logic                             mem_regwrite,
  input  logic [rv32i_pkg::reg_addr_w-1:0] wb_rd,
  input  logic                             wb_regwrite,
  input  logic                             redirect,
  output logic                             stall,
  output logic                             flush,
  output rv32i_pkg::fwd_e                  fwd_a,
  output rv32i_pkg::fwd_e                  fwd_b
);

  import rv32i_pkg::*;

  logic uses_rs1;    // Execute instruction reads rs1
  logic uses_rs2;    // Reads rs2 as operand or store data
  logic load_in_ex;

  // Youngest producer wins
  function automatic fwd_e fwd_sel(input logic [reg_addr_w-1:0] src);
    if (src == '0)
      return fwd_none;  // x0 stays zero
    else if (mem_regwrite && mem_rd == src)
      return fwd_mem;
    else if (wb_regwrite && wb_rd == src)
      return fwd_wb;
    else
      return fwd_none;
  endfunction

  assign uses_rs1 = !(id_ex.ctrl.lui || id_ex.ctrl.jal);
  assign uses_rs2 = !id_ex.ctrl.alusrc || id_ex.ctrl.memwrite;

  always_comb
  begin
    fwd_a = uses_rs1 ? fwd_sel(id_ex.rs1) : fwd_none;
    fwd_b = uses_rs2 ? fwd_sel(id_ex.rs2) : fwd_none;
  end

  ////////////////////////////////
  // Stall and flush
  ////////////////////////////////

  // Load data only exists in memory stage, one cycle too late for execute
  assign load_in_ex = id_ex.ctrl.memtoreg && id_ex.rd != '0;
  assign stall      = load_in_ex && (id_ex.rd == id_rs1 || id_ex.rd == id_rs2);
  assign flush      = redirect;  // Kill fetch/decode and decode/execute slots

  // A stalling load never writes memory and never redirects
  always_comb
  begin
    if (stall)
      assert (id_ex.ctrl.regwrite && !id_ex.ctrl.memwrite && !redirect)
        else $error("stall raised without a plain load in execute");
  end

endmodule

`default_nettype wire

// ==== verilog/rv32i_cpu.sv ====
// RV32I five-stage in-order core
//   Fetch, decode, execute, memory and writeback
//   Forwarding into execute, one-cycle load-use stall
//   Branches and jumps resolve in execute and flush two slots
//   Instruction and data memories sit outside, both read combinationally

`timescale 1ns/1ps
`default_nettype none

module rv32i_cpu (
  input  logic                       clk,
  input  logic                       reset,
  output logic [rv32i_pkg::xlen-1:0] pc,
  input  logic [rv32i_pkg::xlen-1:0] inst,
  output logic                       mem_write,
  output logic [rv32i_pkg::xlen-1:0] mem_addr,
  output logic [rv32i_pkg::xlen-1:0] mem_wdata,
  input  logic [rv32i_pkg::xlen-1:0] mem_rdata
);

  import rv32i_pkg::*;

  // Fetch/decode register
  logic [xlen-1:0]       if_pc;
  logic [xlen-1:0]       if_inst;

  // Decode
  ctrl_t                 id_ctrl;
  logic [reg_addr_w-1:0] id_rs1;
  logic [reg_addr_w-1:0] id_rs2;
  logic [reg_addr_w-1:0] id_rd;
  logic [xlen-1:0]       id_imm;
  br_e                   id_funct3;
  logic [xlen-1:0]       id_rs1_data;
  logic [xlen-1:0]       id_rs2_data;

  // Stage registers
  id_ex_t                id_ex;
  ex_mem_t               ex_mem;
  mem_wb_t               mem_wb;

  // Execute
  fwd_e                  fwd_a;
  fwd_e                  fwd_b;
  logic [xlen-1:0]       mem_fwd_data;  // Value ex_mem will write back
  logic [xlen-1:0]       ex_rs1;
  logic [xlen-1:0]       ex_rs2;
  logic [xlen-1:0]       alu_b;
  logic [xlen-1:0]       alu_result;
  logic                  alu_zero;
  logic                  br_taken;
  logic                  redirect;
  logic [xlen-1:0]       target;

  logic                  stall;
  logic                  flush;
  logic [xlen-1:0]       mem_result;    // Writeback select

  // Forwarded operand, shared by both ports
  function automatic logic [xlen-1:0] fwd_mux(input fwd_e            sel,
                                              input logic [xlen-1:0] rf_data,
                                              input logic [xlen-1:0] mem_data,
                                              input logic [xlen-1:0] wb_data);
    case (sel)
      fwd_mem: return mem_data;
      fwd_wb:  return wb_data;
      default: return rf_data;
    endcase
  endfunction

  ////////////////////////////////
  // Fetch
  ////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= reset_pc;
    else if (redirect)
      pc <= target;            // Target fetched next cycle
    else if (!stall)
      pc <= pc + pc_step;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      if_pc   <= reset_pc;
      if_inst <= nop_inst;
    end
    else if (flush)
      if_inst <= nop_inst;     // Wrong-path fetch
    else if (!stall)
    begin
      if_pc   <= pc;
      if_inst <= inst;
    end
  end

  ////////////////////////////////
  // Decode
  ////////////////////////////////

  rv32i_decoder u_decoder (
    .inst   (if_inst),
    .ctrl   (id_ctrl),
    .rs1    (id_rs1),
    .rs2    (id_rs2),
    .rd     (id_rd),
    .imm    (id_imm),
    .funct3 (id_funct3)
  );

  rv32i_regfile u_regfile (
    .clk     (clk),
    .reset   (reset),
    .we      (mem_wb.regwrite),  // Writeback port
    .waddr   (mem_wb.rd),
    .wdata   (mem_wb.wb_data),
    .raddr_a (id_rs1),
    .raddr_b (id_rs2),
    .rdata_a (id_rs1_data),
    .rdata_b (id_rs2_data)
  );

  rv32i_hazard u_hazard (
    .id_rs1       (id_rs1),
    .id_rs2       (id_rs2),
    .id_ex        (id_ex),
    .mem_rd       (ex_mem.rd),
    .mem_regwrite (ex_mem.regwrite),
    .wb_rd        (mem_wb.rd),
    .wb_regwrite  (mem_wb.regwrite),
    .redirect     (redirect),
    .stall        (stall),
    .flush        (flush),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex <= '0;
    else
    begin
      id_ex.pc       <= if_pc;
      id_ex.rs1_data <= id_rs1_data;
      id_ex.rs2_data <= id_rs2_data;
      id_ex.imm      <= id_imm;
      id_ex.rs1      <= id_rs1;
      id_ex.rs2      <= id_rs2;
      id_ex.rd       <= id_rd;
      id_ex.funct3   <= id_funct3;
      if (stall || flush)
        id_ex.ctrl <= '0;      // Bubble
      else
        id_ex.ctrl <= id_ctrl;
    end
  end

  ////////////////////////////////
  // Execute
  ////////////////////////////////

  assign mem_fwd_data = ex_mem.link ? ex_mem.link_addr : ex_mem.alu_result;
  assign ex_rs1 = fwd_mux(fwd_a, id_ex.rs1_data, mem_fwd_data, mem_wb.wb_data);
  assign ex_rs2 = fwd_mux(fwd_b, id_ex.rs2_data, mem_fwd_data, mem_wb.wb_data);
  assign alu_b  = id_ex.ctrl.alusrc ? id_ex.imm : ex_rs2;

  rv32i_alu u_alu (
    .a      (ex_rs1),
    .b      (alu_b),
    .op     (id_ex.ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // Branch decision
  always_comb
  begin
    case (id_ex.funct3)
      br_eq:   br_taken = id_ex.ctrl.branch && alu_zero;
      br_ne:   br_taken = id_ex.ctrl.branch && !alu_zero;
      default: br_taken = 1'b0;
    endcase
  end

  assign redirect = br_taken || id_ex.ctrl.jal || id_ex.ctrl.jalr;
  assign target   = id_ex.ctrl.jalr ? {alu_result[xlen-1:1], 1'b0}  // rs1 + imm
                                    : id_ex.pc + id_ex.imm;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ex_mem <= '0;
    else
    begin
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= ex_rs2;           // Forwarded store data
      ex_mem.link_addr  <= id_ex.pc + pc_step;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.regwrite   <= id_ex.ctrl.regwrite;
      ex_mem.memtoreg   <= id_ex.ctrl.memtoreg;
      ex_mem.memwrite   <= id_ex.ctrl.memwrite;
      ex_mem.link       <= id_ex.ctrl.jal || id_ex.ctrl.jalr;
    end
  end

  ////////////////////////////////
  // Memory and writeback
  ////////////////////////////////

  assign mem_write = ex_mem.memwrite;
  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;

  assign mem_result = ex_mem.memtoreg ? mem_rdata :
                      ex_mem.link     ? ex_mem.link_addr : ex_mem.alu_result;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mem_wb <= '0;
    else
    begin
      mem_wb.wb_data  <= mem_result;
      mem_wb.rd       <= ex_mem.rd;
      mem_wb.regwrite <= ex_mem.regwrite;
    end
  end

  // Loads never redirect, so the two controls never meet
  a_no_stall_on_redirect: assert property (@(posedge clk) disable iff (reset)
    !(stall && redirect));

endmodule

`default_nettype wire

// ==== verif/rv32i_tb.sv ====
// Testbench for the RV32I pipeline
//   Clock, reset, instruction ROM and data RAM models
//   Program table built with small instruction encoders
//   Ordered check of every store against a table of expected stores
//   Stray-store window after the last store, then the report

`timescale 1ns/1ps
`default_nettype none

module rv32i_tb;

  // RV32I major opcodes, written out here from the ISA manual
  localparam logic [6:0] opc_r      = 7'b0110011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [31:0] nop       = 32'h0000_0013;  // addi x0, x0, 0

  localparam int num_stores    = 16;
  localparam int store_timeout = 40;   // Cycles allowed between two stores
  localparam int drain_cycles  = 40;   // Stray-store watch after the last store

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_t;

  // Expected stores in program order, worked out by hand
  localparam store_t expected [num_stores] = '{
    '{32'h0000_0000, 32'h0000_0016},  // add   12 + 10
    '{32'h0000_0004, 32'h0000_0002},  // sub   12 - 10
    '{32'h0000_0008, 32'h0000_0008},  // and
    '{32'h0000_000c, 32'h0000_000e},  // or
    '{32'h0000_0010, 32'h0000_0004},  // andi  12 & 6
    '{32'h0000_0014, 32'h0000_000f},  // ori   12 | 3
    '{32'h0000_0018, 32'hffff_fff3},  // xori  12 ^ -1
    '{32'h0000_001c, 32'h1234_5000},  // lui
    '{32'h0000_0020, 32'h0000_0012},  // Forwarding chain, 11 + 7
    '{32'h0000_0024, 32'h0000_0006},  // addi at distance 1
    '{32'h0000_0028, 32'h0000_0055},  // Data for the load
    '{32'h0000_002c, 32'h0000_0061},  // Load-use, 0x55 + 12
    '{32'h0000_0030, 32'h0000_000a},  // Fall-through of not-taken beq
    '{32'h0000_0034, 32'h0000_000c},  // Fall-through of not-taken bne
    '{32'h0000_0038, 32'h0000_009c},  // jal link
    '{32'h0000_003c, 32'h0000_00b0}   // jalr link
  };

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] inst;
  logic        mem_write;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;

  logic [31:0] rom [0:63];
  logic [31:0] ram [0:63];

  int checked;
  int value_errors;
  int other_errors;

  ////////////////////////////////
  // Instruction encoders
  ////////////////////////////////

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_r};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // sw only
  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  ////////////////////////////////
  // DUT and memory models
  ////////////////////////////////

  rv32i_cpu u_dut (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  assign inst      = rom[pc[7:2]];        // Combinational fetch
  assign mem_rdata = ram[mem_addr[7:2]];  // Combinational load

  always @(posedge clk)
  begin
    if (mem_write)
      ram[mem_addr[7:2]] <= mem_wdata;
  end

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Program table, word index on the left
  initial
  begin
    for (int i = 0; i < 64; i++)
    begin
      rom[i] = nop;
      ram[i] = 32'ha5a5_0000 | i;  // Marks each word by its index
    end
    rom[0]  = i_type(12'd12, 5'd0, 3'b000, 5'd1, opc_imm);     // addi x1, x0, 12
    rom[1]  = i_type(12'd10, 5'd0, 3'b000, 5'd2, opc_imm);     // addi x2, x0, 10
    rom[2]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);         // add  x3, x1, x2
    rom[3]  = s_type(12'd0, 5'd3, 5'd0);
    rom[4]  = r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);         // sub
    rom[5]  = s_type(12'd4, 5'd4, 5'd0);
    rom[6]  = r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);         // and
    rom[7]  = s_type(12'd8, 5'd5, 5'd0);
    rom[8]  = r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);         // or
    rom[9]  = s_type(12'd12, 5'd6, 5'd0);
    rom[10] = i_type(12'd6, 5'd1, 3'b111, 5'd7, opc_imm);      // andi
    rom[11] = s_type(12'd16, 5'd7, 5'd0);
    rom[12] = i_type(12'd3, 5'd1, 3'b110, 5'd8, opc_imm);      // ori
    rom[13] = s_type(12'd20, 5'd8, 5'd0);
    rom[14] = i_type(12'hfff, 5'd1, 3'b100, 5'd9, opc_imm);    // xori x9, x1, -1
    rom[15] = s_type(12'd24, 5'd9, 5'd0);
    rom[16] = {20'h12345, 5'd10, opc_lui};                     // lui x10
    rom[17] = s_type(12'd28, 5'd10, 5'd0);
    // Chains at distances 1, 2 and 3
    rom[18] = i_type(12'd5, 5'd0, 3'b000, 5'd11, opc_imm);
    rom[19] = i_type(12'd1, 5'd11, 3'b000, 5'd12, opc_imm);
    rom[20] = i_type(12'd7, 5'd0, 3'b000, 5'd13, opc_imm);
    rom[21] = r_type(7'h00, 5'd12, 5'd11, 3'b000, 5'd14);
    rom[22] = r_type(7'h00, 5'd13, 5'd14, 3'b000, 5'd15);
    rom[23] = s_type(12'd32, 5'd15, 5'd0);
    rom[24] = s_type(12'd36, 5'd12, 5'd0);
    // Load-use pair
    rom[25] = i_type(12'h055, 5'd0, 3'b000, 5'd16, opc_imm);
    rom[26] = s_type(12'd40, 5'd16, 5'd0);
    rom[27] = i_type(12'd40, 5'd0, 3'b010, 5'd17, opc_load);  // lw x17, 40(x0)
    rom[28] = r_type(7'h00, 5'd1, 5'd17, 3'b000, 5'd18);
    rom[29] = s_type(12'd44, 5'd18, 5'd0);
    // Branches, taken ones skip a store with a wrong value
    rom[30] = b_type(13'd8, 5'd1, 5'd1, 3'b000);               // beq taken
    rom[31] = s_type(12'd48, 5'd1, 5'd0);
    rom[32] = b_type(13'd8, 5'd2, 5'd1, 3'b001);               // bne taken
    rom[33] = s_type(12'd48, 5'd1, 5'd0);
    rom[34] = b_type(13'd8, 5'd2, 5'd1, 3'b000);               // beq not taken
    rom[35] = s_type(12'd48, 5'd2, 5'd0);
    rom[36] = b_type(13'd8, 5'd1, 5'd1, 3'b001);               // bne not taken
    rom[37] = s_type(12'd52, 5'd1, 5'd0);
    // Jumps
    rom[38] = j_type(21'd12, 5'd19);                           // jal x19, +12
    rom[39] = s_type(12'd56, 5'd0, 5'd0);
    rom[40] = s_type(12'd56, 5'd0, 5'd0);
    rom[41] = s_type(12'd56, 5'd19, 5'd0);
    rom[42] = i_type(12'd184, 5'd0, 3'b000, 5'd20, opc_imm);
    rom[43] = i_type(12'd4, 5'd20, 3'b000, 5'd21, opc_jalr);  // jalr x21, 4(x20)
    rom[44] = s_type(12'd60, 5'd0, 5'd0);
    rom[45] = s_type(12'd60, 5'd0, 5'd0);
    rom[46] = s_type(12'd60, 5'd0, 5'd0);
    rom[47] = s_type(12'd60, 5'd21, 5'd0);
    rom[48] = j_type(21'd0, 5'd0);                             // Park here
  end

  ////////////////////////////////
  // Checks
  ////////////////////////////////

  // Next store, sampled mid-cycle
  task automatic wait_store(output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < store_timeout)
    begin
      @(negedge clk);
      cycles++;
      if (mem_write)
        seen = 1'b1;
    end
  endtask

  task automatic check_store(input store_t exp);
    checked++;
    assert (mem_addr == exp.addr)
      else
      begin
        $display("Fail mem_addr: got %h, expected %h", mem_addr, exp.addr);
        value_errors++;
      end
    assert (mem_wdata == exp.data)
      else
      begin
        $display("Fail mem_wdata: got %h, expected %h", mem_wdata, exp.data);
        value_errors++;
      end
  endtask

  initial
  begin
    bit seen;
    bit timed_out;
    checked      = 0;
    value_errors = 0;
    other_errors = 0;
    timed_out    = 1'b0;
    reset        = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    for (int n = 0; n < num_stores && !timed_out; n++)
    begin
      wait_store(seen);
      if (!seen)
      begin
        $display("No store seen within %0d cycles, waiting for store %0d to address %h",
                 store_timeout, n, expected[n].addr);
        other_errors++;
        timed_out = 1'b1;
      end
      else
        check_store(expected[n]);
    end

    // Program is parked in a jal loop, nothing more may be written
    if (!timed_out)
    begin
      for (int c = 0; c < drain_cycles; c++)
      begin
        @(negedge clk);
        assert (!mem_write)
          else
          begin
            $display("Store outside the expected list, address %h data %h",
                     mem_addr, mem_wdata);
            other_errors++;
          end
      end
    end

    $display("Stores checked: %0d, value errors: %0d, other errors: %0d",
             checked, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/rv32i_pkg.sv
verilog/rv32i_decoder.sv
verilog/rv32i_regfile.sv
verilog/rv32i_alu.sv
verilog/rv32i_hazard.sv
verilog/rv32i_cpu.sv
verif/rv32i_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP       = rv32i_tb
RTL_TOP   = rv32i_cpu
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
